/* hdl/dissector_pkg.sv */
package dissector_pkg;

    // Stream beat layout, RGB pixels packed three bytes each
    localparam int PIXELS_PER_BEAT = 8;
    localparam int BYTES_PER_PIXEL = 3;
    localparam int BEAT_BYTES      = PIXELS_PER_BEAT * BYTES_PER_PIXEL;

    // Image size in beats
    localparam int ROW_BEATS   = 6;
    localparam int ROWS        = 8;
    localparam int FRAME_BEATS = ROW_BEATS * ROWS;

    // Four parity banks, each holds a quarter frame per buffer
    localparam int NUM_BANKS   = 4;
    localparam int BANK_WORDS  = FRAME_BEATS / NUM_BANKS;
    localparam int BANK_ADDR_W = 4;

    // Counter widths for the write side
    localparam int BEAT_CNT_W = $clog2(FRAME_BEATS);
    localparam int ROW_CNT_W  = $clog2(ROWS);
    localparam int COL_CNT_W  = $clog2(ROW_BEATS);

    typedef logic [BEAT_BYTES*8-1:0]      beat_t;
    typedef logic [PIXELS_PER_BEAT*8-1:0] pixel_word_t;
    typedef logic [BANK_ADDR_W-1:0]       bank_addr_t;

    // Bank number is {row parity, column parity}, 1 means odd
    typedef logic [1:0] bank_idx_t;

    // Lane 3 is the most significant word
    typedef pixel_word_t [NUM_BANKS-1:0] read_line_t;

    // Odd row, odd column
    localparam bank_idx_t BANK_OO = 2'b11;

endpackage

/* hdl/beat_steering.sv */
module beat_steering
    import dissector_pkg::*;
(
    input  logic                 ACLK,
    input  logic                 rst,
    input  beat_t                s_tdata,
    input  logic                 s_tvalid,
    input  logic                 s_tlast,
    input  logic                 s_tuser,
    input  logic                 stall,
    input  logic                 write_buf,
    output logic                 s_tready,
    output logic [NUM_BANKS-1:0] wr_en,
    output bank_addr_t           wr_addr,
    output logic                 wr_buf,
    output pixel_word_t          wr_data,
    output logic                 frame_done
);

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        DONE
    } state_t;

    state_t                state;
    state_t                next_state;
    logic [BEAT_CNT_W-1:0] beat_cnt;
    logic [ROW_CNT_W-1:0]  row_cnt;
    logic [COL_CNT_W-1:0]  col_cnt;
    logic                  accept;
    logic                  frame_last;
    logic                  restart;
    bank_idx_t             bank;

    // DONE gives one dead cycle, then hold off while the swap is pending
    assign s_tready   = (state != DONE) && !stall;
    assign accept     = s_tvalid && s_tready;
    assign frame_last = (beat_cnt == BEAT_CNT_W'(FRAME_BEATS - 1));
    assign frame_done = accept && frame_last;

    // Start of frame marker from upstream, only honoured between rows
    assign restart = (state == IDLE) && s_tuser && !s_tvalid;

    always_ff @(posedge ACLK or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE, DATA: begin
                if (accept) begin
                    if (frame_last) begin
                        next_state = DONE;
                    end else if (s_tlast) begin
                        next_state = IDLE;
                    end else begin
                        next_state = DATA;
                    end
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // Position of the next beat within the frame
    always_ff @(posedge ACLK or negedge rst) begin
        if (!rst) begin
            beat_cnt <= '0;
            row_cnt  <= '0;
            col_cnt  <= '0;
        end else if (restart || (accept && frame_last)) begin
            beat_cnt <= '0;
            row_cnt  <= '0;
            col_cnt  <= '0;
        end else if (accept) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (s_tlast) begin
                row_cnt <= row_cnt + 1'b1;
                col_cnt <= '0;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // First byte of each RGB triple, pixel 0 comes from the top of the beat
    always_comb begin
        for (int b = 0; b < PIXELS_PER_BEAT; b++) begin
            wr_data[b*8 +: 8] = s_tdata[(PIXELS_PER_BEAT-1-b)*BYTES_PER_PIXEL*8 +: 8];
        end
    end

    assign bank = {row_cnt[0], col_cnt[0]};

    // Each bank sees every other row and every other column
    assign wr_addr = bank_addr_t'((row_cnt >> 1) * (ROW_BEATS / 2) + (col_cnt >> 1));

    always_comb begin
        wr_en = '0;
        if (accept) begin
            wr_en[bank] = 1'b1;
        end
    end

    assign wr_buf = write_buf;

endmodule

/* hdl/frame_bank.sv */
module frame_bank
    import dissector_pkg::*;
(
    input  logic        ACLK,
    input  logic        wr_en,
    input  logic        wr_buf,
    input  bank_addr_t  wr_addr,
    input  pixel_word_t wr_data,
    input  logic        rd_buf,
    input  bank_addr_t  rd_addr,
    output pixel_word_t rd_word
);

    // Buffer 0 in the lower half, buffer 1 above it
    pixel_word_t mem [2*BANK_WORDS];

    logic [BANK_ADDR_W:0] wr_index;
    logic [BANK_ADDR_W:0] rd_index;

    assign wr_index = (BANK_ADDR_W+1)'(wr_addr)
                    + (wr_buf ? (BANK_ADDR_W+1)'(BANK_WORDS) : '0);

    // Addresses past BANK_WORDS alias into the other half, the lane gets masked later
    assign rd_index = (BANK_ADDR_W+1)'(rd_addr)
                    + (rd_buf ? (BANK_ADDR_W+1)'(BANK_WORDS) : '0);

    always_ff @(posedge ACLK) begin
        if (wr_en) begin
            mem[wr_index] <= wr_data;
        end
    end

    // Registered read like a block RAM port
    always_ff @(posedge ACLK) begin
        rd_word <= mem[rd_index];
    end

endmodule

/* hdl/buffer_control.sv */
module buffer_control (
    input  logic ACLK,
    input  logic rst,
    input  logic frame_done,
    input  logic transfer_done,
    output logic stall,
    output logic write_buf,
    output logic read_buf,
    output logic interrupt,
    output logic frame_ready
);

    // Finished frame waiting for the reader to let go of the other buffer
    logic pending;
    logic swap;

    // A frame can be handed over when the reader is free or finishes this cycle.
    // A held frame goes once frame_ready has dropped
    assign swap = (frame_done && (!frame_ready || transfer_done))
                || (pending && !frame_ready);

    always_ff @(posedge ACLK or negedge rst) begin
        if (!rst) begin
            write_buf   <= 1'b0;
            pending     <= 1'b0;
            interrupt   <= 1'b0;
            frame_ready <= 1'b0;
        end else begin
            interrupt <= swap;
            if (swap) begin
                write_buf   <= !write_buf;
                pending     <= 1'b0;
                frame_ready <= 1'b1;
            end else begin
                // Reader still busy with the previous frame
                if (frame_done) begin
                    pending <= 1'b1;
                end
                if (transfer_done) begin
                    frame_ready <= 1'b0;
                end
            end
        end
    end

    // Writer waits for the swap before it takes the next frame
    assign stall = pending;

    // Ping-pong, reader always on the buffer the writer is not using
    assign read_buf = !write_buf;

endmodule

/* hdl/readout_reorder.sv */
module readout_reorder
    import dissector_pkg::*;
(
    input  logic                        ACLK,
    input  logic                        rst,
    input  bank_addr_t [NUM_BANKS-1:0]  rd_addr,
    input  logic                        rd_odd_row,
    input  logic                        rd_odd_col,
    input  pixel_word_t [NUM_BANKS-1:0] bank_words,
    output read_line_t                  rd_data
);

    bank_idx_t            parity_q;
    logic [NUM_BANKS-1:0] in_range_q;
    bank_idx_t            sel [NUM_BANKS];

    // Sampled on the same edge as the bank reads, so they line up with bank_words
    always_ff @(posedge ACLK or negedge rst) begin
        if (!rst) begin
            parity_q   <= '0;
            in_range_q <= '0;
        end else begin
            parity_q <= {rd_odd_row, rd_odd_col};
            for (int i = 0; i < NUM_BANKS; i++) begin
                in_range_q[i] <= (int'(rd_addr[i]) < BANK_WORDS);
            end
        end
    end

    // Top lane takes the bank matching the requested parity,
    // lower lanes flip column, then row, then both
    always_comb begin
        for (int l = 0; l < NUM_BANKS; l++) begin
            sel[l] = parity_q ^ BANK_OO ^ bank_idx_t'(l);
        end
    end

    always_comb begin
        for (int l = 0; l < NUM_BANKS; l++) begin
            if (in_range_q[sel[l]]) begin
                rd_data[l] = bank_words[sel[l]];
            end else begin
                rd_data[l] = '0;
            end
        end
    end

endmodule

/* hdl/image_dissector.sv */
module image_dissector
    import dissector_pkg::*;
(
    input  logic                       ACLK,
    input  logic                       rst,
    input  beat_t                      s_tdata,
    input  logic                       s_tvalid,
    input  logic                       s_tlast,
    input  logic                       s_tuser,
    output logic                       s_tready,
    input  logic                       transfer_done,
    input  bank_addr_t [NUM_BANKS-1:0] rd_addr,
    input  logic                       rd_odd_row,
    input  logic                       rd_odd_col,
    output read_line_t                 rd_data,
    output logic                       interrupt,
    output logic                       frame_ready
);

    logic                        stall;
    logic                        write_buf;
    logic                        read_buf;
    logic                        frame_done;
    logic [NUM_BANKS-1:0]        wr_en;
    bank_addr_t                  wr_addr;
    logic                        wr_buf;
    pixel_word_t                 wr_data;
    pixel_word_t [NUM_BANKS-1:0] bank_words;

    beat_steering steering_i (
        .ACLK       (ACLK),
        .rst        (rst),
        .s_tdata    (s_tdata),
        .s_tvalid   (s_tvalid),
        .s_tlast    (s_tlast),
        .s_tuser    (s_tuser),
        .stall      (stall),
        .write_buf  (write_buf),
        .s_tready   (s_tready),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_buf     (wr_buf),
        .wr_data    (wr_data),
        .frame_done (frame_done)
    );

    buffer_control control_i (
        .ACLK          (ACLK),
        .rst           (rst),
        .frame_done    (frame_done),
        .transfer_done (transfer_done),
        .stall         (stall),
        .write_buf     (write_buf),
        .read_buf      (read_buf),
        .interrupt     (interrupt),
        .frame_ready   (frame_ready)
    );

    // One bank per parity pair, index {row parity, column parity}
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        frame_bank bank_i (
            .ACLK    (ACLK),
            .wr_en   (wr_en[g]),
            .wr_buf  (wr_buf),
            .wr_addr (wr_addr),
            .wr_data (wr_data),
            .rd_buf  (read_buf),
            .rd_addr (rd_addr[g]),
            .rd_word (bank_words[g])
        );
    end

    readout_reorder reorder_i (
        .ACLK       (ACLK),
        .rst        (rst),
        .rd_addr    (rd_addr),
        .rd_odd_row (rd_odd_row),
        .rd_odd_col (rd_odd_col),
        .bank_words (bank_words),
        .rd_data    (rd_data)
    );

endmodule

/* bench/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic ACLK,
    output logic rst
);

    initial begin
        ACLK = 1'b0;
        forever #(PERIOD / 2) ACLK = ~ACLK;
    end

    // Release away from the rising edge
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge ACLK);
        @(negedge ACLK);
        rst = 1'b1;
    end

endmodule

/* bench/image_dissector_tb.sv */
module image_dissector_tb
    import dissector_pkg::*;
();

    localparam int CLK_PERIOD      = 4;
    localparam int READ_CYCLES     = 4 * BANK_WORDS;
    localparam int WATCHDOG_CYCLES = 4 * (4 * (FRAME_BEATS + READ_CYCLES));
    localparam int WAIT_LIMIT      = 32;
    localparam int STALL_CHECKS    = 6;

    logic                       ACLK;
    logic                       rst;
    beat_t                      s_tdata;
    logic                       s_tvalid;
    logic                       s_tlast;
    logic                       s_tuser;
    logic                       s_tready;
    logic                       transfer_done;
    bank_addr_t [NUM_BANKS-1:0] rd_addr;
    logic                       rd_odd_row;
    logic                       rd_odd_col;
    read_line_t                 rd_data;
    logic                       interrupt;
    logic                       frame_ready;

    // Expected contents of the buffer the reader sees after the next swap
    pixel_word_t exp_mem [NUM_BANKS][BANK_WORDS];

    int    seed = 32'h7446_acb4;
    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    errors_at_start = 0;
    int    irq_count = 0;
    int    irq_before = 0;
    int    row_pos = 0;
    int    col_pos = 0;
    string test_name = "none";

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) clock_i (.ACLK(ACLK), .rst(rst));

    image_dissector image_dissector_i (
        .ACLK          (ACLK),
        .rst           (rst),
        .s_tdata       (s_tdata),
        .s_tvalid      (s_tvalid),
        .s_tlast       (s_tlast),
        .s_tuser       (s_tuser),
        .s_tready      (s_tready),
        .transfer_done (transfer_done),
        .rd_addr       (rd_addr),
        .rd_odd_row    (rd_odd_row),
        .rd_odd_col    (rd_odd_col),
        .rd_data       (rd_data),
        .interrupt     (interrupt),
        .frame_ready   (frame_ready)
    );

    always @(posedge ACLK) begin
        if (rst && interrupt) begin
            irq_count++;
        end
    end

    assert property (@(posedge ACLK) disable iff (!rst) interrupt |=> !interrupt)
        else begin
            errors++;
            $display("Interrupt stayed high longer than one cycle");
        end

    assert property (@(posedge ACLK) disable iff (!rst) interrupt |-> frame_ready)
        else begin
            errors++;
            $display("Interrupt pulsed while frame_ready was low");
        end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ACLK);
        $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
        $display("Done: errors found");
        $finish;
    end

    // Pixel b is byte 3*(PIXELS_PER_BEAT-1-b) of the beat
    function automatic pixel_word_t extract_pixels(input beat_t beat);
        pixel_word_t word;
        int          byte_idx;
        for (int b = 0; b < PIXELS_PER_BEAT; b++) begin
            byte_idx = BYTES_PER_PIXEL * (PIXELS_PER_BEAT - 1 - b);
            word[b*8 +: 8] = beat[byte_idx*8 +: 8];
        end
        return word;
    endfunction

    // Lanes 3..0 hold banks {R,C}, {R,~C}, {~R,C}, {~R,~C}
    function automatic int lane_bank(input int lane, input logic odd_row, input logic odd_col);
        logic row_par;
        logic col_par;
        row_par = (lane >= 2) ? odd_row : !odd_row;
        col_par = (lane == 3 || lane == 1) ? odd_col : !odd_col;
        return 2 * int'(row_par) + int'(col_par);
    endfunction

    function automatic read_line_t expected_line(input bank_addr_t [NUM_BANKS-1:0] addrs,
                                                 input logic odd_row, input logic odd_col);
        read_line_t line;
        int         bank;
        int         addr;
        for (int lane = 0; lane < NUM_BANKS; lane++) begin
            bank = lane_bank(lane, odd_row, odd_col);
            addr = int'(addrs[bank]);
            line[lane] = (addr < BANK_WORDS) ? exp_mem[bank][addr] : '0;
        end
        return line;
    endfunction

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        $display("Test %s finished with %0d errors", test_name, errors - errors_at_start);
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s: %s expected %b, actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("ERROR %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_beat(input beat_t beat, input logic last);
        int waited;
        s_tdata  = beat;
        s_tlast  = last;
        s_tvalid = 1'b1;
        waited   = 0;
        while (!s_tready && waited < WAIT_LIMIT) begin
            @(negedge ACLK);
            waited++;
        end
        if (!s_tready) begin
            errors++;
            $display("Stream never became ready in test %s", test_name);
        end
        @(negedge ACLK);
    endtask

    task automatic send_beats(input int count);
        beat_t beat;
        logic  last;
        int    bank;
        int    addr;
        for (int n = 0; n < count; n++) begin
            for (int i = 0; i < BEAT_BYTES / 4; i++) begin
                beat[i*32 +: 32] = $random(seed);
            end
            last = (col_pos == ROW_BEATS - 1);
            bank = 2 * (row_pos % 2) + (col_pos % 2);
            addr = (row_pos / 2) * (ROW_BEATS / 2) + col_pos / 2;
            exp_mem[bank][addr] = extract_pixels(beat);
            send_beat(beat, last);
            col_pos = last ? 0 : col_pos + 1;
            row_pos = last ? (row_pos + 1) % ROWS : row_pos;
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    task automatic wait_interrupt(input int target);
        int waited;
        waited = 0;
        while (irq_count < target && waited < WAIT_LIMIT) begin
            @(negedge ACLK);
            waited++;
        end
        if (irq_count < target) begin
            errors++;
            $display("No interrupt arrived in test %s", test_name);
        end
    endtask

    task automatic pulse_transfer_done();
        transfer_done = 1'b1;
        @(negedge ACLK);
        transfer_done = 1'b0;
    endtask

    // Data is due one cycle after the address is sampled
    task automatic read_check(input bank_addr_t [NUM_BANKS-1:0] addrs,
                              input logic odd_row, input logic odd_col);
        read_line_t expected;
        rd_addr    = addrs;
        rd_odd_row = odd_row;
        rd_odd_col = odd_col;
        expected   = expected_line(addrs, odd_row, odd_col);
        @(negedge ACLK);
        checks++;
        assert (rd_data === expected) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", test_name, expected, rd_data);
        end
    endtask

    // Every word with every parity and each lane on its own address
    task automatic read_frame();
        bank_addr_t [NUM_BANKS-1:0] addrs;
        for (int p = 0; p < 4; p++) begin
            for (int a = 0; a < BANK_WORDS; a++) begin
                for (int b = 0; b < NUM_BANKS; b++) begin
                    addrs[b] = bank_addr_t'((a + b) % BANK_WORDS);
                end
                read_check(addrs, p[1], p[0]);
            end
        end
        rd_addr = '0;
    endtask

    task automatic mask_reads();
        bank_addr_t [NUM_BANKS-1:0] addrs;
        for (int m = 1; m < (1 << NUM_BANKS); m++) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (m[b]) begin
                    addrs[b] = bank_addr_t'(BANK_WORDS
                               + (m + b) % ((1 << BANK_ADDR_W) - BANK_WORDS));
                end else begin
                    addrs[b] = bank_addr_t'((m + b) % BANK_WORDS);
                end
            end
            read_check(addrs, m[0], m[1] ^ m[2]);
        end
        rd_addr = '0;
    endtask

    initial begin
        s_tdata       = '0;
        s_tvalid      = 1'b0;
        s_tlast       = 1'b0;
        s_tuser       = 1'b0;
        transfer_done = 1'b0;
        rd_addr       = '0;
        rd_odd_row    = 1'b0;
        rd_odd_col    = 1'b0;
        @(posedge rst);
        @(negedge ACLK);

        start_test("reset");
        check_bit("s_tready", 1'b1, s_tready);
        check_bit("interrupt", 1'b0, interrupt);
        check_bit("frame_ready", 1'b0, frame_ready);
        end_test();

        start_test("frame_readback");
        irq_before = irq_count;
        send_beats(FRAME_BEATS);
        wait_interrupt(irq_before + 1);
        repeat (4) @(negedge ACLK);
        check_count("interrupt pulses", irq_before + 1, irq_count);
        check_bit("frame_ready", 1'b1, frame_ready);
        read_frame();
        end_test();

        // Reader still owns the first frame, so the writer must hold
        start_test("backpressure");
        irq_before = irq_count;
        send_beats(FRAME_BEATS);
        repeat (STALL_CHECKS) begin
            check_bit("s_tready", 1'b0, s_tready);
            @(negedge ACLK);
        end
        check_count("interrupt pulses", irq_before, irq_count);
        check_bit("frame_ready", 1'b1, frame_ready);
        pulse_transfer_done();
        wait_interrupt(irq_before + 1);
        repeat (4) @(negedge ACLK);
        check_count("interrupt pulses", irq_before + 1, irq_count);
        check_bit("s_tready", 1'b1, s_tready);
        read_frame();
        end_test();

        start_test("restart");
        irq_before = irq_count;
        send_beats(FRAME_BEATS / 2);
        s_tuser = 1'b1;
        repeat (2) @(negedge ACLK);
        s_tuser = 1'b0;
        row_pos = 0;
        col_pos = 0;
        pulse_transfer_done();
        check_bit("frame_ready", 1'b0, frame_ready);
        send_beats(FRAME_BEATS);
        wait_interrupt(irq_before + 1);
        repeat (4) @(negedge ACLK);
        check_count("interrupt pulses", irq_before + 1, irq_count);
        read_frame();
        end_test();

        // Both buffers now hold data, so out of range lanes alias onto written words
        start_test("range_mask");
        mask_reads();
        end_test();

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* image_dissector.f */
hdl/dissector_pkg.sv
hdl/beat_steering.sv
hdl/frame_bank.sv
hdl/buffer_control.sv
hdl/readout_reorder.sv
hdl/image_dissector.sv
bench/tb_clock.sv
bench/image_dissector_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module image_dissector_tb \
    -f image_dissector.f \
    -o image_dissector_sim

./obj_dir/image_dissector_sim | tee sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
